/* logic/bp_params.svh */
// Size and width settings for the branch predictor, included by the package and the RTL
`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Datapath
// ~~~~~~~~~~~~~~~~~~~~
`define BP_XLEN 32

// ~~~~~~~~~~~~~~~~~~~~
// Tables
// ~~~~~~~~~~~~~~~~~~~~
`define BP_BTB_ENTRIES 16
`define BP_GHR_BITS 5     // Also the PHT index width

// ~~~~~~~~~~~~~~~~~~~~
// Resolution queue
// ~~~~~~~~~~~~~~~~~~~~
`define BP_QUEUE_DEPTH 4  // Max unresolved control transfers

`endif

/* logic/bp_pkg.sv */
// Shared opcodes, branch kinds and block-to-block records, imported by the predictor RTL
`default_nettype none

`include "bp_params.svh"

package bp_pkg;

    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    typedef enum logic [1:0] {
        KIND_NONE = 2'd0,
        KIND_COND = 2'd1,
        KIND_JUMP = 2'd2
    } br_kind_e;

    // ~~~~~~~~~~~~~~~~~~~~
    // Interface records
    // ~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [`BP_XLEN-1:0] pc;
        logic [6:0]          op;
    } lookup_req_t;

    typedef struct packed {
        logic                taken;
        logic [`BP_XLEN-1:0] target;
    } prediction_t;

    typedef struct packed {
        logic [`BP_XLEN-1:0]     pc;
        br_kind_e                kind;
        logic [`BP_GHR_BITS-1:0] pht_idx;  // Counter used at lookup
        logic                    taken;
        logic [`BP_XLEN-1:0]     target;
    } pred_rec_t;

    typedef struct packed {
        logic                taken;
        logic [`BP_XLEN-1:0] target;
    } resolve_t;

    typedef struct packed {
        logic [`BP_XLEN-1:0] pc;
        logic [`BP_XLEN-1:0] target;
        br_kind_e            kind;
    } btb_wr_t;

    typedef struct packed {
        logic [`BP_GHR_BITS-1:0] idx;
        logic                    up;
    } pht_train_t;

    typedef struct packed {
        logic [`BP_XLEN-1:0] pc;
    } redirect_t;

endpackage

`default_nettype wire

/* logic/btb.sv */
// Direct-mapped branch target buffer with full-pc tags, read by lookup and written by update
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

module btb (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic [`BP_XLEN-1:0]  rd_pc_i,
    input  logic                 wr_valid_i,
    input  bp_pkg::btb_wr_t      wr_i,
    output logic                 hit_o,
    output bp_pkg::br_kind_e     kind_o,
    output logic [`BP_XLEN-1:0]  target_o
);
    import bp_pkg::*;

    localparam int IDX_BITS = $clog2(`BP_BTB_ENTRIES);

    logic [`BP_BTB_ENTRIES-1:0] valid_q;
    logic [`BP_XLEN-1:0]        tag_q    [`BP_BTB_ENTRIES];
    logic [`BP_XLEN-1:0]        target_q [`BP_BTB_ENTRIES];
    br_kind_e                   kind_q   [`BP_BTB_ENTRIES];

    logic [IDX_BITS-1:0] rd_idx;
    logic [IDX_BITS-1:0] wr_idx;

    assign rd_idx = rd_pc_i[IDX_BITS+1:2];    // Word-aligned pc bits
    assign wr_idx = wr_i.pc[IDX_BITS+1:2];

    // ~~~~~~~~~~~~~~~~~~~~
    // Read port
    // ~~~~~~~~~~~~~~~~~~~~
    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_pc_i);
    assign kind_o   = kind_q[rd_idx];
    assign target_o = target_q[rd_idx];

    // ~~~~~~~~~~~~~~~~~~~~
    // Write port
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (wr_valid_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_valid_i) begin
            tag_q[wr_idx]    <= wr_i.pc;
            target_q[wr_idx] <= wr_i.target;
            kind_q[wr_idx]   <= wr_i.kind;  // Whole entry replaced
        end
    end

endmodule

`default_nettype wire

/* logic/gshare_pht.sv */
// Gshare history register and 2-bit counter table, read at lookup and trained at resolution
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

module gshare_pht (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic [`BP_XLEN-1:0]     rd_pc_i,
    input  logic                    train_valid_i,
    input  bp_pkg::pht_train_t      train_i,
    output logic [`BP_GHR_BITS-1:0] rd_idx_o,
    output logic                    rd_taken_o
);
    import bp_pkg::*;

    localparam int ENTRIES = 1 << `BP_GHR_BITS;

    logic [`BP_GHR_BITS-1:0] ghr_q;
    logic [1:0]              cnt_q [ENTRIES];
    logic [1:0]              cnt_cur;

    assign rd_idx_o   = rd_pc_i[`BP_GHR_BITS+1:2] ^ ghr_q;
    assign rd_taken_o = cnt_q[rd_idx_o][1];  // High bit predicts taken
    assign cnt_cur    = cnt_q[train_i.idx];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < ENTRIES; i++) begin
                cnt_q[i] <= 2'b01;  // Weakly not taken
            end
        end else if (train_valid_i) begin
            if (train_i.up && cnt_cur != 2'b11) begin
                cnt_q[train_i.idx] <= cnt_cur + 2'b01;
            end else if (!train_i.up && cnt_cur != 2'b00) begin
                cnt_q[train_i.idx] <= cnt_cur - 2'b01;
            end
        end
    end

    // Newest outcome enters at bit 0
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ghr_q <= '0;
        end else if (train_valid_i) begin
            ghr_q <= {ghr_q[`BP_GHR_BITS-2:0], train_i.up};
        end
    end

endmodule

`default_nettype wire

/* logic/pred_queue.sv */
// In-order queue of prediction records waiting for execute to resolve them
`timescale 1ns/1ps
`default_nettype none

module pred_queue #(
    parameter int DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              push_i,
    input  bp_pkg::pred_rec_t rec_i,
    input  logic              pop_i,
    output bp_pkg::pred_rec_t head_o,
    output logic              empty_o,
    output logic              full_o
);
    import bp_pkg::*;

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    pred_rec_t                 mem_q [DEPTH];
    logic [PTR_BITS-1:0]       wr_ptr_q;
    logic [PTR_BITS-1:0]       rd_ptr_q;
    logic [$clog2(DEPTH+1)-1:0] count_q;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == DEPTH[$clog2(DEPTH+1)-1:0]);

    // A record pushed this cycle is already visible when the queue is empty
    assign head_o = empty_o ? rec_i : mem_q[rd_ptr_q];

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) wr_ptr_q <= next_ptr(wr_ptr_q);
            if (pop_i)  rd_ptr_q <= next_ptr(rd_ptr_q);
            if (push_i && !pop_i) begin
                count_q <= count_q + 1'b1;
            end else if (!push_i && pop_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) mem_q[wr_ptr_q] <= rec_i;  // Payload only
    end

endmodule

`default_nettype wire

/* logic/bp_lookup.sv */
// Lookup stage that decodes the opcode, forms the registered prediction and queues the record
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

module bp_lookup (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    lookup_valid_i,
    input  bp_pkg::lookup_req_t     lookup_req_i,
    input  logic                    btb_hit_i,
    input  bp_pkg::br_kind_e        btb_kind_i,
    input  logic [`BP_XLEN-1:0]     btb_target_i,
    input  logic [`BP_GHR_BITS-1:0] pht_idx_i,
    input  logic                    pht_taken_i,
    output logic                    pred_valid_o,
    output bp_pkg::prediction_t     prediction_o,
    output logic                    push_o,
    output bp_pkg::pred_rec_t       rec_o
);
    import bp_pkg::*;

    br_kind_e dec_kind;
    logic     pred_taken;
    logic [`BP_XLEN-1:0] pred_target;

    always_comb begin
        case (lookup_req_i.op)
            OP_BRANCH:       dec_kind = KIND_COND;
            OP_JAL, OP_JALR: dec_kind = KIND_JUMP;
            default:         dec_kind = KIND_NONE;
        endcase
    end

    // Jumps always taken on a hit, branches follow the counter
    assign pred_taken  = btb_hit_i && ((btb_kind_i == KIND_JUMP) ||
                         (btb_kind_i == KIND_COND && pht_taken_i));
    assign pred_target = pred_taken ? btb_target_i : lookup_req_i.pc + `BP_XLEN'd4;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pred_valid_o <= 1'b0;
            push_o       <= 1'b0;
        end else begin
            pred_valid_o <= lookup_valid_i;
            push_o       <= lookup_valid_i && (dec_kind != KIND_NONE);
        end
    end

    always_ff @(posedge clk) begin
        prediction_o <= '{taken: pred_taken, target: pred_target};
        rec_o        <= '{pc: lookup_req_i.pc, kind: dec_kind, pht_idx: pht_idx_i,
                          taken: pred_taken, target: pred_target};
    end

endmodule

`default_nettype wire

/* logic/bp_update.sv */
// Update stage that pairs each resolution with the oldest record, trains the tables and redirects
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

module bp_update (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               resolve_valid_i,
    input  bp_pkg::resolve_t   resolve_i,
    input  bp_pkg::pred_rec_t  head_i,
    output logic               pop_o,
    output logic               btb_wr_valid_o,
    output bp_pkg::btb_wr_t    btb_wr_o,
    output logic               pht_train_valid_o,
    output bp_pkg::pht_train_t pht_train_o,
    output logic               redirect_valid_o,
    output bp_pkg::redirect_t  redirect_o
);
    import bp_pkg::*;

    logic mispredict;
    logic [`BP_XLEN-1:0] fix_pc;

    assign pop_o = resolve_valid_i;

    // Wrong direction, or right direction to the wrong place
    assign mispredict = (head_i.taken != resolve_i.taken) ||
                        (head_i.taken && resolve_i.taken && head_i.target != resolve_i.target);
    assign fix_pc     = resolve_i.taken ? resolve_i.target : head_i.pc + `BP_XLEN'd4;

    // ~~~~~~~~~~~~~~~~~~~~
    // Table training
    // ~~~~~~~~~~~~~~~~~~~~
    assign btb_wr_valid_o    = resolve_valid_i && resolve_i.taken;
    assign btb_wr_o          = '{pc: head_i.pc, target: resolve_i.target, kind: head_i.kind};
    assign pht_train_valid_o = resolve_valid_i && (head_i.kind == KIND_COND);
    assign pht_train_o       = '{idx: head_i.pht_idx, up: resolve_i.taken};

    // ~~~~~~~~~~~~~~~~~~~~
    // Redirect
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            redirect_valid_o <= 1'b0;
        end else begin
            redirect_valid_o <= resolve_valid_i && mispredict;
        end
    end

    always_ff @(posedge clk) begin
        redirect_o.pc <= fix_pc;
    end

endmodule

`default_nettype wire

/* logic/branch_predictor.sv */
// Top level of the fetch branch predictor, wiring the tables, lookup, queue and update stages
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

module branch_predictor (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                lookup_valid_i,
    input  bp_pkg::lookup_req_t lookup_req_i,
    input  logic                resolve_valid_i,
    input  bp_pkg::resolve_t    resolve_i,
    output logic                pred_valid_o,
    output bp_pkg::prediction_t prediction_o,
    output logic                redirect_valid_o,
    output bp_pkg::redirect_t   redirect_o
);
    import bp_pkg::*;

    logic                    btb_hit;
    br_kind_e                btb_kind;
    logic [`BP_XLEN-1:0]     btb_target;
    logic [`BP_GHR_BITS-1:0] pht_idx;
    logic                    pht_taken;

    logic       q_push;
    logic       q_pop;
    logic       q_empty;  // Watched by the bound checker
    logic       q_full;
    pred_rec_t  q_rec;
    pred_rec_t  q_head;

    logic       btb_wr_valid;
    btb_wr_t    btb_wr;
    logic       pht_train_valid;
    pht_train_t pht_train;

    btb u_btb (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rd_pc_i    (lookup_req_i.pc),
        .wr_valid_i (btb_wr_valid),
        .wr_i       (btb_wr),
        .hit_o      (btb_hit),
        .kind_o     (btb_kind),
        .target_o   (btb_target)
    );

    gshare_pht u_pht (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .rd_pc_i       (lookup_req_i.pc),
        .train_valid_i (pht_train_valid),
        .train_i       (pht_train),
        .rd_idx_o      (pht_idx),
        .rd_taken_o    (pht_taken)
    );

    bp_lookup u_lookup (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .lookup_valid_i (lookup_valid_i),
        .lookup_req_i   (lookup_req_i),
        .btb_hit_i      (btb_hit),
        .btb_kind_i     (btb_kind),
        .btb_target_i   (btb_target),
        .pht_idx_i      (pht_idx),
        .pht_taken_i    (pht_taken),
        .pred_valid_o   (pred_valid_o),
        .prediction_o   (prediction_o),
        .push_o         (q_push),
        .rec_o          (q_rec)
    );

    pred_queue #(
        .DEPTH (`BP_QUEUE_DEPTH)
    ) u_queue (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .push_i  (q_push),
        .rec_i   (q_rec),
        .pop_i   (q_pop),
        .head_o  (q_head),
        .empty_o (q_empty),
        .full_o  (q_full)
    );

    bp_update u_update (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .resolve_valid_i   (resolve_valid_i),
        .resolve_i         (resolve_i),
        .head_i            (q_head),
        .pop_o             (q_pop),
        .btb_wr_valid_o    (btb_wr_valid),
        .btb_wr_o          (btb_wr),
        .pht_train_valid_o (pht_train_valid),
        .pht_train_o       (pht_train),
        .redirect_valid_o  (redirect_valid_o),
        .redirect_o        (redirect_o)
    );

endmodule

`default_nettype wire

/* bench/bp_clock_gen.sv */
// Free-running clock source for the predictor testbench, instantiated by the bench top
`timescale 1ns/1ps
`default_nettype none

module bp_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;  // 50% duty
    end

endmodule

`default_nettype wire

/* bench/bp_properties.sv */
// Concurrent checks on queue use and strobe timing, bound into the predictor top level
`timescale 1ns/1ps
`default_nettype none

module bp_properties (
    input logic clk,
    input logic rst_n_i,
    input logic lookup_valid_i,
    input logic pred_valid_i,
    input logic resolve_valid_i,
    input logic redirect_valid_i,
    input logic push_i,
    input logic pop_i,
    input logic full_i,
    input logic empty_i
);

    int unsigned violations = 0;  // Read by the bench at the end

    // ~~~~~~~~~~~~~~~~~~~~
    // Queue use
    // ~~~~~~~~~~~~~~~~~~~~
    push_when_full_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(push_i && full_i && !pop_i))
        else begin
            violations++;
            $error("queue push while full and not popping");
        end

    // Empty queue may still pop the record being pushed
    pop_when_empty_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        pop_i |-> (!empty_i || push_i))
        else begin
            violations++;
            $error("queue pop while empty");
        end

    // ~~~~~~~~~~~~~~~~~~~~
    // Strobe timing
    // ~~~~~~~~~~~~~~~~~~~~
    pred_after_lookup_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        pred_valid_i == $past(lookup_valid_i))
        else begin
            violations++;
            $error("pred_valid_o not exactly one cycle after lookup_valid_i");
        end

    redirect_after_resolve_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        redirect_valid_i |-> $past(resolve_valid_i))
        else begin
            violations++;
            $error("redirect_valid_o without a resolution in the cycle before");
        end

endmodule

bind branch_predictor bp_properties u_props (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .lookup_valid_i   (lookup_valid_i),
    .pred_valid_i     (pred_valid_o),
    .resolve_valid_i  (resolve_valid_i),
    .redirect_valid_i (redirect_valid_o),
    .push_i           (q_push),
    .pop_i            (q_pop),
    .full_i           (q_full),
    .empty_i          (q_empty)
);

`default_nettype wire

/* bench/tb_branch_predictor.sv */
// Testbench that replays bench/bp_input.txt on the predictor and checks it against a model
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

module tb_branch_predictor;
    import bp_pkg::*;

    localparam int WAIT_LIMIT  = 8;
    localparam int BTB_IDX     = $clog2(`BP_BTB_ENTRIES);
    localparam int PHT_ENTRIES = 1 << `BP_GHR_BITS;

    logic        clk;
    logic        rst_n;
    logic        lookup_valid;
    lookup_req_t lookup_req;
    logic        resolve_valid;
    resolve_t    resolve_req;
    logic        pred_valid;
    prediction_t prediction;
    logic        redirect_valid;
    redirect_t   redirect;

    // Reference model state
    logic                    m_btb_valid [`BP_BTB_ENTRIES];
    logic [`BP_XLEN-1:0]     m_btb_tag   [`BP_BTB_ENTRIES];
    logic [`BP_XLEN-1:0]     m_btb_tgt   [`BP_BTB_ENTRIES];
    br_kind_e                m_btb_kind  [`BP_BTB_ENTRIES];
    logic [1:0]              m_pht       [PHT_ENTRIES];
    logic [`BP_GHR_BITS-1:0] m_ghr;
    pred_rec_t               m_queue     [$];

    int   errors;
    int   tests;
    logic timed_out;

    bp_clock_gen #(.PERIOD_NS(40)) u_clk (.clk(clk));

    branch_predictor UUT (
        .clk              (clk),
        .rst_n_i          (rst_n),
        .lookup_valid_i   (lookup_valid),
        .lookup_req_i     (lookup_req),
        .resolve_valid_i  (resolve_valid),
        .resolve_i        (resolve_req),
        .pred_valid_o     (pred_valid),
        .prediction_o     (prediction),
        .redirect_valid_o (redirect_valid),
        .redirect_o       (redirect)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic reset_model();
        for (int i = 0; i < `BP_BTB_ENTRIES; i++) begin
            m_btb_valid[i] = 1'b0;
            m_btb_kind[i]  = KIND_NONE;
        end
        for (int i = 0; i < PHT_ENTRIES; i++) begin
            m_pht[i] = 2'b01;  // Weakly not taken
        end
        m_ghr = '0;
        m_queue.delete();
    endtask

    function automatic br_kind_e decode_kind(input logic [6:0] op);
        if (op == OP_BRANCH) return KIND_COND;
        if (op == OP_JAL || op == OP_JALR) return KIND_JUMP;
        return KIND_NONE;
    endfunction

    task automatic model_lookup(input logic [`BP_XLEN-1:0] pc, input logic [6:0] op,
                                output prediction_t exp);
        logic [BTB_IDX-1:0]      bi;
        logic [`BP_GHR_BITS-1:0] pi;
        logic                    hit;
        pred_rec_t               rec;
        bi  = pc[BTB_IDX+1:2];
        pi  = pc[`BP_GHR_BITS+1:2] ^ m_ghr;
        hit = m_btb_valid[bi] && (m_btb_tag[bi] == pc);
        exp.taken  = hit && (m_btb_kind[bi] == KIND_JUMP ||
                             (m_btb_kind[bi] == KIND_COND && m_pht[pi][1]));
        exp.target = exp.taken ? m_btb_tgt[bi] : pc + 32'd4;
        rec = '{pc: pc, kind: decode_kind(op), pht_idx: pi, taken: exp.taken,
                target: exp.target};
        if (rec.kind != KIND_NONE) m_queue.push_back(rec);
    endtask

    task automatic model_resolve(input logic taken, input logic [`BP_XLEN-1:0] target,
                                 output logic exp_valid, output redirect_t exp);
        pred_rec_t          rec;
        logic [BTB_IDX-1:0] bi;
        rec = m_queue.pop_front();
        bi  = rec.pc[BTB_IDX+1:2];
        exp_valid = (rec.taken != taken) || (rec.taken && taken && rec.target != target);
        exp.pc    = taken ? target : rec.pc + 32'd4;
        if (taken) begin
            m_btb_valid[bi] = 1'b1;
            m_btb_tag[bi]   = rec.pc;
            m_btb_tgt[bi]   = target;
            m_btb_kind[bi]  = rec.kind;
        end
        if (rec.kind == KIND_COND) begin
            if (taken && m_pht[rec.pht_idx] != 2'd3) begin
                m_pht[rec.pht_idx] = m_pht[rec.pht_idx] + 2'd1;
            end else if (!taken && m_pht[rec.pht_idx] != 2'd0) begin
                m_pht[rec.pht_idx] = m_pht[rec.pht_idx] - 2'd1;
            end
            m_ghr = {m_ghr[`BP_GHR_BITS-2:0], taken};
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic check_prediction(input prediction_t exp, input prediction_t act,
                                    output logic ok);
        ok = 1'b1;
        if (act.taken !== exp.taken) begin
            $display("FAIL %0t prediction_o.taken expected %0b got %0b",
                     $time, exp.taken, act.taken);
            ok = 1'b0;
        end
        if (act.target !== exp.target) begin
            $display("FAIL %0t prediction_o.target expected %h got %h",
                     $time, exp.target, act.target);
            ok = 1'b0;
        end
        if (!ok) errors++;
    endtask

    task automatic check_redirect(input logic exp_valid, input redirect_t exp,
                                  input logic act_valid, input redirect_t act,
                                  output logic ok);
        ok = 1'b1;
        if (act_valid !== exp_valid) begin
            $display("FAIL %0t redirect_valid_o expected %0b got %0b",
                     $time, exp_valid, act_valid);
            ok = 1'b0;
        end else if (exp_valid && act.pc !== exp.pc) begin
            $display("FAIL %0t redirect_o.pc expected %h got %h", $time, exp.pc, act.pc);
            ok = 1'b0;
        end
        if (!ok) errors++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Operations
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic run_lookup(input logic [`BP_XLEN-1:0] pc, input logic [6:0] op,
                              output logic ok);
        prediction_t exp;
        int          waited;
        model_lookup(pc, op, exp);
        lookup_valid = 1'b1;
        lookup_req   = '{pc: pc, op: op};
        @(posedge clk);
        @(negedge clk);
        lookup_valid = 1'b0;
        waited = 0;
        while (!pred_valid && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!pred_valid) begin
            $display("ERROR at %0t: no prediction within %0d cycles of the lookup",
                     $time, WAIT_LIMIT);
            timed_out = 1'b1;
            errors++;
            ok = 1'b0;
        end else begin
            check_prediction(exp, prediction, ok);
        end
    endtask

    // Redirect is sampled in the cycle right after the resolution
    task automatic run_resolve(input logic taken, input logic [`BP_XLEN-1:0] target,
                               output logic ok);
        logic      exp_valid;
        redirect_t exp;
        if (m_queue.size() == 0) begin
            $display("ERROR at %0t: resolution with no control transfer in flight", $time);
            errors++;
            ok = 1'b0;
        end else begin
            model_resolve(taken, target, exp_valid, exp);
            resolve_valid = 1'b1;
            resolve_req   = '{taken: taken, target: target};
            @(posedge clk);
            @(negedge clk);
            resolve_valid = 1'b0;
            check_redirect(exp_valid, exp, redirect_valid, redirect, ok);
        end
    endtask

    initial begin
        int                  fd;
        int                  n;
        string               line;
        byte                 cmd;
        logic [`BP_XLEN-1:0] a;
        logic [`BP_XLEN-1:0] b;
        logic                ok;
        rst_n         = 1'b0;
        lookup_valid  = 1'b0;
        lookup_req    = '0;
        resolve_valid = 1'b0;
        resolve_req   = '0;
        errors        = 0;
        tests         = 0;
        timed_out     = 1'b0;
        reset_model();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        fd = $fopen("bench/bp_input.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open bench/bp_input.txt");
            errors++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                n = $fgets(line, fd);
                if (n == 0 || line.len() < 2 || line[0] == "#") continue;
                n = $sscanf(line, "%c %h %h", cmd, a, b);
                if (n == 3 && cmd == "L") begin
                    run_lookup(a, b[6:0], ok);
                    tests++;
                    $display("test %0d lookup pc %h op %h: %s", tests, a, b[6:0],
                             ok ? "ok" : "mismatch");
                end else if (n == 3 && cmd == "R") begin
                    run_resolve(a[0], b, ok);
                    tests++;
                    $display("test %0d resolve taken %0b target %h: %s", tests, a[0], b,
                             ok ? "ok" : "mismatch");
                end else begin
                    $display("ERROR: unreadable stimulus line: %s", line);
                    errors++;
                end
            end
            $fclose(fd);
        end

        repeat (2) @(negedge clk);  // Let the last assertions sample
        errors += UUT.u_props.violations;
        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* branch_predictor.f */
+incdir+logic
logic/bp_pkg.sv
logic/btb.sv
logic/gshare_pht.sv
logic/pred_queue.sv
logic/bp_lookup.sv
logic/bp_update.sv
logic/branch_predictor.sv
bench/bp_clock_gen.sv
bench/bp_properties.sv
bench/tb_branch_predictor.sv

/* bench/bp_input.txt */
# L <pc hex> <opcode hex>        lookup, predicted from the tables
# R <taken 0/1> <target hex>     resolution of the oldest lookup in flight
L 00000108 63
R 1 00000180
L 00000200 6f
R 1 00000400
L 00000200 6f
R 1 00000400
L 00000240 6f
R 0 00000000
L 00000200 6f
R 1 00000600
L 00000200 6f
R 1 00000600
L 00000108 63
R 1 00000180
L 00000108 63
R 1 00000180
L 00000108 63
R 1 00000180
L 00000108 63
R 1 00000180
L 00000108 63
R 1 00000180
L 00000108 63
R 1 00000180
L 00000108 63
R 1 00000180
L 00000108 63
R 0 00000000
L 00000108 63
R 0 00000000
L 00000108 63
R 0 00000000
L 00000108 63
R 1 00000180
L 00000108 63
R 0 00000000
L 00000108 63
R 1 00000180
L 00000340 13
L 00000344 63
L 00000348 33
L 0000034c 67
L 00000350 6f
L 00000354 63
R 1 00000320
R 0 00000000
R 1 00000500
R 0 00000000
L 00000344 63
R 1 00000320
L 00000350 6f
R 1 00000500
